/* logic/dup_compare.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module dup_compare (
    input  wire purge_pkg::track_entry_t    primary,
    input  wire purge_pkg::track_entry_t    secondary,
    output logic                            is_dup
);

    import purge_pkg::*;

    localparam int SHARE_W = $clog2(`N_LAYER + 1);

    logic [SHARE_W-1:0] shared;     // Layers with a common stub
    logic               same_seed;

    // Only real stubs count, a zero id on either side never matches
    always_comb begin
        shared = '0;
        for (int l = 0; l < `N_LAYER; l++) begin
            if (primary.stubs.stub_id[l] != '0 &&
                primary.stubs.stub_id[l] == secondary.stubs.stub_id[l]) begin
                shared = shared + 1'b1;
            end
        end
    end

    assign same_seed = (primary.seed == secondary.seed);

    // Tracks of one seed group are never duplicates of each other
    assign is_dup = (shared >= SHARE_W'(`SHARED_MIN)) && !same_seed;

endmodule

`default_nettype wire

/* logic/purge_cfg.svh */
`ifndef PURGE_CFG_SVH
`define PURGE_CFG_SVH

// Seeding groups and track slots per group
`define N_SEED          3
`define SLOTS_PER_SEED  4
`define N_TRACKS        (`N_SEED * `SLOTS_PER_SEED)

// Stub layout of one track
`define N_LAYER         6
`define STUB_ID_W       9

// Shared nonzero stubs that make two tracks duplicates
`define SHARED_MIN      3

// Index and count widths
`define TRACK_IDX_W     4
`define COUNT_W         3

`endif

/* logic/purge_duplicate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module purge_duplicate (
    input  wire                         clk,
    input  wire                         rst_pipe,
    input  wire                         start,
    input  wire purge_pkg::seed_input_t seed_in [`N_SEED],
    output wire                         busy,
    output wire purge_pkg::verdict_t    verdict,
    output wire                         verdict_valid,
    output wire                         done
);

    import purge_pkg::*;

    //////////////////////////////
    // Loader to sequencer
    //////////////////////////////

    track_entry_t           track_table [`N_TRACKS];
    wire [`N_TRACKS-1:0]    present;
    wire                    loaded;     // Table valid from here on

    track_loader u_loader (
        .clk         (clk),
        .rst_pipe    (rst_pipe),
        .start       (start),
        .busy        (busy),
        .seed_in     (seed_in),
        .track_table (track_table),
        .present     (present),
        .loaded      (loaded)
    );

    // One verdict per present track, then done
    removal_sequencer u_seq (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .loaded        (loaded),
        .track_table   (track_table),
        .present       (present),
        .busy          (busy),
        .verdict       (verdict),
        .verdict_valid (verdict_valid),
        .done          (done)
    );

endmodule

`default_nettype wire

/* logic/purge_pkg.sv */
`default_nettype none

`include "purge_cfg.svh"

package purge_pkg;

    typedef logic [$clog2(`N_SEED)-1:0] seed_num_t;    // Seed group number

    // Stub ids of one track, id 0 means no stub in that layer
    typedef struct packed {
        logic [`N_LAYER-1:0][`STUB_ID_W-1:0] stub_id;
    } stub_set_t;

    // One seed group as delivered by the track finder
    typedef struct packed {
        logic [`COUNT_W-1:0]                count;
        stub_set_t [`SLOTS_PER_SEED-1:0]    slot;
    } seed_input_t;

    // Entry of the captured track table
    typedef struct packed {
        stub_set_t  stubs;
        seed_num_t  seed;
    } track_entry_t;

    // Verdict for one track of the run
    typedef struct packed {
        logic [`TRACK_IDX_W-1:0]    idx;    // Global track index
        seed_num_t                  seed;
        logic                       kept;   // Low when purged as duplicate
    } verdict_t;

endpackage

`default_nettype wire

/* logic/removal_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module removal_sequencer (
    input  wire                             clk,
    input  wire                             rst_pipe,
    input  wire                             loaded,
    input  wire purge_pkg::track_entry_t    track_table [`N_TRACKS],
    input  wire [`N_TRACKS-1:0]             present,
    output logic                            busy,
    output purge_pkg::verdict_t             verdict,
    output logic                            verdict_valid,
    output logic                            done
);

    import purge_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_RUN    = 2'd1;
    localparam logic [1:0] ST_FINISH = 2'd2;

    logic [1:0]                 state;
    logic [`TRACK_IDX_W-1:0]    prim_idx;       // Current primary
    logic [`N_TRACKS-1:0]       dup_flags;      // Set when purged by a kept track
    track_entry_t               prim_entry;
    logic                       prim_kept;
    logic [`N_TRACKS-1:0]       is_dup;
    logic [`N_TRACKS-1:0]       later_mask;     // Indices above the primary
    logic [`TRACK_IDX_W:0]      first_hit;      // {found, index}
    logic [`TRACK_IDX_W:0]      next_hit;

    // Lowest set bit of a mask, found flag on top
    function automatic logic [`TRACK_IDX_W:0] find_first(input logic [`N_TRACKS-1:0] mask);
        logic [`TRACK_IDX_W:0] hit;
        hit = '0;
        for (int i = `N_TRACKS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                hit = {1'b1, `TRACK_IDX_W'(i)};
            end
        end
        return hit;
    endfunction

    //////////////////////////////
    // Comparator array
    //////////////////////////////

    assign prim_entry = track_table[prim_idx];
    assign prim_kept  = !dup_flags[prim_idx];

    for (genvar t = 0; t < `N_TRACKS; t++) begin : g_cmp
        dup_compare u_cmp (
            .primary   (prim_entry),
            .secondary (track_table[t]),
            .is_dup    (is_dup[t])
        );
    end

    //////////////////////////////
    // Primary stepping
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `N_TRACKS; i++) begin
            later_mask[i] = (`TRACK_IDX_W'(i) > prim_idx);
        end
    end

    assign first_hit = find_first(present);
    assign next_hit  = find_first(present & later_mask);    // Skips absent slots

    assign busy = loaded || (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            state         <= ST_IDLE;
            prim_idx      <= '0;
            dup_flags     <= '0;
            verdict_valid <= 1'b0;
            done          <= 1'b0;
        end else begin
            verdict_valid <= 1'b0;
            done          <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (loaded) begin
                        dup_flags <= '0;
                        if (first_hit[`TRACK_IDX_W]) begin
                            prim_idx <= first_hit[`TRACK_IDX_W-1:0];
                            state    <= ST_RUN;
                        end else begin
                            state    <= ST_FINISH;  // Nothing present
                        end
                    end
                end
                ST_RUN: begin
                    verdict_valid <= 1'b1;
                    // A purged primary purges nothing
                    if (prim_kept) begin
                        dup_flags <= dup_flags | (is_dup & present & later_mask);
                    end
                    if (next_hit[`TRACK_IDX_W]) begin
                        prim_idx <= next_hit[`TRACK_IDX_W-1:0];
                    end else begin
                        state    <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Verdict payload, qualified by verdict_valid
    always_ff @(posedge clk) begin
        if (state == ST_RUN) begin
            verdict.idx  <= prim_idx;
            verdict.seed <= prim_entry.seed;
            verdict.kept <= prim_kept;
        end
    end

endmodule

`default_nettype wire

/* logic/track_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module track_loader (
    input  wire                         clk,
    input  wire                         rst_pipe,
    input  wire                         start,
    input  wire                         busy,
    input  wire purge_pkg::seed_input_t seed_in [`N_SEED],
    output purge_pkg::track_entry_t     track_table [`N_TRACKS],
    output logic [`N_TRACKS-1:0]        present,
    output logic                        loaded
);

    import purge_pkg::*;

    logic                   accept;
    logic [`COUNT_W-1:0]    count_q [`N_SEED];  // Clipped per-seed counts

    // A new run only starts when the sequencer is free
    assign accept = start && !busy;

    //////////////////////////////
    // Capture of counts and strobe
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            loaded <= 1'b0;
            for (int s = 0; s < `N_SEED; s++) begin
                count_q[s] <= '0;
            end
        end else begin
            loaded <= accept;
            if (accept) begin
                for (int s = 0; s < `N_SEED; s++) begin
                    if (seed_in[s].count > `COUNT_W'(`SLOTS_PER_SEED)) begin
                        count_q[s] <= `COUNT_W'(`SLOTS_PER_SEED);   // Clip
                    end else begin
                        count_q[s] <= seed_in[s].count;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Track table
    //////////////////////////////

    // Slots are stored in global order, seed number tagged on each entry
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int s = 0; s < `N_SEED; s++) begin
                for (int k = 0; k < `SLOTS_PER_SEED; k++) begin
                    track_table[s*`SLOTS_PER_SEED + k].stubs <= seed_in[s].slot[k];
                    track_table[s*`SLOTS_PER_SEED + k].seed  <= seed_num_t'(s);
                end
            end
        end
    end

    //////////////////////////////
    // Presence mask
    //////////////////////////////

    // Slot present when below its seed's count, an empty seed gives all zeros
    always_comb begin
        for (int s = 0; s < `N_SEED; s++) begin
            for (int k = 0; k < `SLOTS_PER_SEED; k++) begin
                present[s*`SLOTS_PER_SEED + k] = (`COUNT_W'(k) < count_q[s]);
            end
        end
    end

endmodule

`default_nettype wire

/* sim/purge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module purge_checker (
    input  wire                         clk,
    input  wire                         rst_pipe,
    input  wire                         start,
    input  wire purge_pkg::seed_input_t seed_in [`N_SEED],
    input  wire                         busy,
    input  wire purge_pkg::verdict_t    verdict,
    input  wire                         verdict_valid,
    input  wire                         done,
    output int                          errors,
    output int                          verdicts_seen,
    output int                          kept_seen
);

    import purge_pkg::*;

    stub_set_t  model_stubs [`N_TRACKS];
    int         model_seed  [`N_TRACKS];
    bit         model_live  [`N_TRACKS];    // Slot below its clipped count
    bit         model_kept  [`N_TRACKS];
    int         exp_idx     [`N_TRACKS];    // Expected verdict stream
    int         exp_seed    [`N_TRACKS];
    bit         exp_kept    [`N_TRACKS];
    int         exp_count;
    bit         pending;                    // Run in progress
    int         cyc;                        // Cycles since the accepted start

    // Layers where both tracks carry the same real stub
    function automatic int shared_stubs(input stub_set_t a, input stub_set_t b);
        int n;
        n = 0;
        for (int l = 0; l < `N_LAYER; l++) begin
            if (a.stub_id[l] != 0 && a.stub_id[l] == b.stub_id[l]) begin
                n++;
            end
        end
        return n;
    endfunction

    // A track falls when an earlier kept track of another seed matches it
    task automatic build_expected();
        int  cnt;
        int  g;
        bit  kept;
        exp_count = 0;
        for (int s = 0; s < `N_SEED; s++) begin
            cnt = seed_in[s].count;
            if (cnt > `SLOTS_PER_SEED) begin
                cnt = `SLOTS_PER_SEED;
            end
            for (int k = 0; k < `SLOTS_PER_SEED; k++) begin
                g = s * `SLOTS_PER_SEED + k;
                model_stubs[g] = seed_in[s].slot[k];
                model_seed[g]  = s;
                model_live[g]  = (k < cnt);
            end
        end
        for (int t = 0; t < `N_TRACKS; t++) begin
            model_kept[t] = 1'b0;
            if (model_live[t]) begin
                kept = 1'b1;
                for (int h = 0; h < t; h++) begin
                    if (model_live[h] && model_kept[h] && model_seed[h] != model_seed[t] &&
                        shared_stubs(model_stubs[h], model_stubs[t]) >= `SHARED_MIN) begin
                        kept = 1'b0;
                    end
                end
                model_kept[t]       = kept;
                exp_idx[exp_count]  = t;
                exp_seed[exp_count] = model_seed[t];
                exp_kept[exp_count] = kept;
                exp_count++;
            end
        end
    endtask

    // Verdict k shows at cycle k+3 and done right after the last one
    task automatic check_cycle();
        int k;
        bit exp_vv;
        bit exp_busy;
        k = cyc - 3;
        exp_vv = (k >= 0) && (k < exp_count);
        exp_busy = (k < exp_count);     // High from loaded up to the done cycle
        if (busy !== exp_busy) begin
            $display("Mismatch busy at cycle %0d: expected 0x%h, got 0x%h",
                     cyc, exp_busy, busy);
            errors++;
        end
        if (verdict_valid !== exp_vv) begin
            $display("Mismatch verdict_valid at cycle %0d: expected 0x%h, got 0x%h",
                     cyc, exp_vv, verdict_valid);
            errors++;
        end
        if (exp_vv && verdict_valid) begin
            verdicts_seen++;
            if (verdict.kept) begin
                kept_seen++;
            end
            if (verdict.idx !== `TRACK_IDX_W'(exp_idx[k])) begin
                $display("Mismatch verdict.idx at verdict %0d: expected 0x%h, got 0x%h",
                         k, `TRACK_IDX_W'(exp_idx[k]), verdict.idx);
                errors++;
            end
            if (verdict.seed !== seed_num_t'(exp_seed[k])) begin
                $display("Mismatch verdict.seed at verdict %0d: expected 0x%h, got 0x%h",
                         k, seed_num_t'(exp_seed[k]), verdict.seed);
                errors++;
            end
            if (verdict.kept !== exp_kept[k]) begin
                $display("Mismatch verdict.kept at verdict %0d: expected 0x%h, got 0x%h",
                         k, exp_kept[k], verdict.kept);
                errors++;
            end
        end
        if (k == exp_count) begin
            if (done !== 1'b1) begin
                $display("ERROR: done did not arrive in the cycle after the last of %0d verdicts",
                         exp_count);
                errors++;
            end
            pending = 1'b0;
        end else if (done) begin
            $display("Mismatch done at cycle %0d: expected 0x0, got 0x%h", cyc, done);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_pipe) begin
            pending = 1'b0;
            errors  = 0;
        end else begin
            if (pending) begin
                cyc++;
                check_cycle();
            end else if (verdict_valid || done) begin
                $display("ERROR: verdict_valid or done high with no run in progress at %0t",
                         $time);
                errors++;
            end
            if (start && !busy) begin
                build_expected();
                pending       = 1'b1;
                cyc           = 0;
                verdicts_seen = 0;
                kept_seen     = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/purge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module purge_properties (
    input wire clk,
    input wire rst_pipe,
    input wire start,
    input wire busy,
    input wire verdict_valid,
    input wire done
);

    //////////////////////////////
    // Top level protocol
    //////////////////////////////

    // The run ends strictly after its last verdict
    done_apart_from_verdict: assert property (
        @(posedge clk) disable iff (rst_pipe) !(done && verdict_valid))
        else $error("done and verdict_valid are high in the same cycle");

    verdict_inside_run: assert property (
        @(posedge clk) disable iff (rst_pipe) verdict_valid |-> busy)
        else $error("verdict_valid is high while busy is low");

    // Producer side, a new run waits for the stage to be free
    start_only_when_free: assert property (
        @(posedge clk) disable iff (rst_pipe) start |-> !busy)
        else $error("start arrived while busy is high");

endmodule

`default_nettype wire

/* sim/tb_purge_duplicate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "purge_cfg.svh"

module tb_purge_duplicate;

    import purge_pkg::*;

    localparam int RANDOM_RUNS  = 40;
    localparam int BUSY_TIMEOUT = 50;
    localparam int DONE_TIMEOUT = 100;     // Cycles from start to done
    localparam int DRIVE_DELAY  = 2;

    logic           clk;
    logic           rst_pipe;
    logic           start;
    seed_input_t    seed_in [`N_SEED];
    wire            busy;
    verdict_t       verdict;
    wire            verdict_valid;
    wire            done;

    int             checker_errors;
    int             verdicts_seen;
    int             kept_seen;
    int             tb_errors;
    int             tests_run;
    integer         seed;
    bit             timed_out;      // Stops the remaining tests

    purge_duplicate u_dut (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .start         (start),
        .seed_in       (seed_in),
        .busy          (busy),
        .verdict       (verdict),
        .verdict_valid (verdict_valid),
        .done          (done)
    );

    purge_checker u_checker (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .start         (start),
        .seed_in       (seed_in),
        .busy          (busy),
        .verdict       (verdict),
        .verdict_valid (verdict_valid),
        .done          (done),
        .errors        (checker_errors),
        .verdicts_seen (verdicts_seen),
        .kept_seen     (kept_seen)
    );

    bind purge_duplicate purge_properties u_props (
        .clk           (clk),
        .rst_pipe      (rst_pipe),
        .start         (start),
        .busy          (busy),
        .verdict_valid (verdict_valid),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int total_errors();
        return checker_errors + tb_errors;
    endfunction

    function automatic stub_set_t pack_stub_ids(input int a0, a1, a2, a3, a4, a5);
        stub_set_t st;
        st.stub_id[0] = `STUB_ID_W'(a0);
        st.stub_id[1] = `STUB_ID_W'(a1);
        st.stub_id[2] = `STUB_ID_W'(a2);
        st.stub_id[3] = `STUB_ID_W'(a3);
        st.stub_id[4] = `STUB_ID_W'(a4);
        st.stub_id[5] = `STUB_ID_W'(a5);
        return st;
    endfunction

    task automatic clear_seeds();
        for (int s = 0; s < `N_SEED; s++) begin
            seed_in[s] = '0;
        end
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    task automatic run_purge();
        int n;
        bit got_done;
        @(posedge clk);
        #DRIVE_DELAY;
        n = 0;
        while (busy && n < BUSY_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        if (busy) begin
            $display("ERROR: busy stayed high for %0d cycles, run not started", BUSY_TIMEOUT);
            tb_errors++;
            timed_out = 1'b1;
        end else begin
            start = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY start = 1'b0;
            n        = 0;
            got_done = 1'b0;
            while (!got_done && n < DONE_TIMEOUT) begin
                @(negedge clk);     // Outputs settled mid cycle
                got_done = done;
                n++;
            end
            if (!got_done) begin
                $display("ERROR: done not seen within %0d cycles of start", DONE_TIMEOUT);
                tb_errors++;
                timed_out = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic expect_counts(input int n_verdicts, input int n_kept);
        if (verdicts_seen != n_verdicts) begin
            $display("Mismatch verdict count: expected 0x%h, got 0x%h", n_verdicts, verdicts_seen);
            tb_errors++;
        end
        if (kept_seen != n_kept) begin
            $display("Mismatch kept count: expected 0x%h, got 0x%h", n_kept, kept_seen);
            tb_errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        tests_run++;
        if (total_errors() == err_mark) begin
            $display("[test %0d] %s: ok", tests_run, name);
        end else begin
            $display("[test %0d] %s: %0d errors", tests_run, name, total_errors() - err_mark);
        end
    endtask

    //////////////////////////////
    // Directed cases
    //////////////////////////////

    task automatic empty_seeds_run();
        clear_seeds();
        run_purge();
        expect_counts(0, 0);
    endtask

    // Seed 1 empty and seed 2 count clipped from 6 to 4
    task automatic distinct_ids_run();
        int g;
        clear_seeds();
        for (int s = 0; s < `N_SEED; s++) begin
            for (int k = 0; k < `SLOTS_PER_SEED; k++) begin
                g = s * `SLOTS_PER_SEED + k;
                seed_in[s].slot[k] = pack_stub_ids(g*8+1, g*8+2, g*8+3, g*8+4, g*8+5, g*8+6);
            end
        end
        seed_in[0].count = 3'd2;
        seed_in[2].count = 3'd6;
        run_purge();
        expect_counts(6, 6);
    endtask

    task automatic cross_seed_sharing();
        clear_seeds();
        seed_in[0].count   = 3'd1;
        seed_in[1].count   = 3'd1;
        seed_in[0].slot[0] = pack_stub_ids(10, 11, 12, 13, 14, 15);
        seed_in[1].slot[0] = pack_stub_ids(10, 11, 12, 50, 51, 52);  // Three shared
        run_purge();
        expect_counts(2, 1);
        seed_in[1].slot[0] = pack_stub_ids(10, 11, 60, 50, 51, 52);  // Two shared
        run_purge();
        expect_counts(2, 2);
        seed_in[0].slot[0] = pack_stub_ids(0, 0, 0, 0, 14, 15);
        seed_in[1].slot[0] = pack_stub_ids(0, 0, 0, 0, 70, 71);      // Zero ids only
        run_purge();
        expect_counts(2, 2);
    endtask

    task automatic same_seed_twins();
        clear_seeds();
        seed_in[0].count   = 3'd2;
        seed_in[0].slot[0] = pack_stub_ids(20, 21, 22, 23, 24, 25);
        seed_in[0].slot[1] = pack_stub_ids(20, 21, 22, 23, 24, 25);
        run_purge();
        expect_counts(2, 2);
    endtask

    // B matches A, C matches only B, so C survives once B is purged
    task automatic purge_chain();
        clear_seeds();
        seed_in[0].count   = 3'd1;
        seed_in[1].count   = 3'd1;
        seed_in[2].count   = 3'd1;
        seed_in[0].slot[0] = pack_stub_ids(10, 11, 12, 13, 14, 15);
        seed_in[1].slot[0] = pack_stub_ids(10, 11, 12, 30, 31, 32);
        seed_in[2].slot[0] = pack_stub_ids(40, 41, 42, 30, 31, 32);
        run_purge();
        expect_counts(3, 2);
    endtask

    // Stub ids from 0 to 3 so that matches are common
    task automatic random_regression();
        for (int r = 0; r < RANDOM_RUNS && !timed_out; r++) begin
            clear_seeds();
            for (int s = 0; s < `N_SEED; s++) begin
                seed_in[s].count = `COUNT_W'({$random(seed)} % 8);
                for (int k = 0; k < `SLOTS_PER_SEED; k++) begin
                    for (int l = 0; l < `N_LAYER; l++) begin
                        seed_in[s].slot[k].stub_id[l] = `STUB_ID_W'({$random(seed)} % 4);
                    end
                end
            end
            run_purge();
        end
    endtask

    initial begin
        int err_mark;
        seed      = 32'h4315_77c0;
        rst_pipe  = 1'b1;
        start     = 1'b0;
        tb_errors = 0;
        tests_run = 0;
        timed_out = 1'b0;
        clear_seeds();
        repeat (16) @(posedge clk);
        #DRIVE_DELAY rst_pipe = 1'b0;

        err_mark = total_errors();
        empty_seeds_run();
        report_test("all seeds empty", err_mark);
        if (!timed_out) begin
            err_mark = total_errors();
            distinct_ids_run();
            report_test("distinct stubs, absent slots skipped", err_mark);
        end
        if (!timed_out) begin
            err_mark = total_errors();
            cross_seed_sharing();
            report_test("sharing across seeds", err_mark);
        end
        if (!timed_out) begin
            err_mark = total_errors();
            same_seed_twins();
            report_test("identical tracks in one seed", err_mark);
        end
        if (!timed_out) begin
            err_mark = total_errors();
            purge_chain();
            report_test("purged track purges nothing", err_mark);
        end
        if (!timed_out) begin
            err_mark = total_errors();
            random_regression();
            report_test("random runs against model", err_mark);
        end

        $display("Summary: %0d tests, %0d checker errors, %0d testbench errors",
                 tests_run, checker_errors, tb_errors);
        if (total_errors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/purge_pkg.sv
logic/dup_compare.sv
logic/track_loader.sv
logic/removal_sequencer.sv
logic/purge_duplicate.sv
sim/purge_properties.sv
sim/purge_checker.sv
sim/tb_purge_duplicate.sv
